// ==== sim.f ====
cpu_pkg.sv
code_rom.sv
decode.sv
step_seq.sv
exec_unit.sv
stack_ram.sv
cpu_top.sv
cpu_assert.sv
tb_clock.sv
tb_cpu.sv

// ==== Makefile ====
all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cpu -o Vtb_cpu

run: build
	./obj_dir/Vtb_cpu 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module tb_cpu

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

        logic        clk2;
        logic        reset;
        logic        hold; // reset held until the program is in
        logic        prog_we;
        logic [7:0]  prog_addr;
        logic [7:0]  prog_data;
        logic [31:0] eax, ebx, ebp, esp, eip;
        logic        retire;
        logic        halted;
        logic        ended;

        // main line calls the routine at 24, jumps over it on return, stops at 36
        logic [7:0] prog [37] = '{
                8'hb8, 8'h78, 8'h56, 8'h34, 8'h12, // 0  mov eax,12345678h
                8'h89, 8'hc3, 8'h01, 8'hd8,        // 5  mov ebx,eax / add eax,ebx
                8'h50, 8'h5d, 8'h6a, 8'hf0, 8'h5d, // 9  push eax, pop ebp, push -16, pop ebp
                8'he8, 8'h05, 8'h00, 8'h00, 8'h00, // 14 call 24
                8'heb, 8'h0f,                      // 19 jmp 36
                8'hf4, 8'hf4, 8'hf4,               // 21 skipped
                8'h55, 8'h89, 8'he5,               // 24 push ebp / mov ebp,esp
                8'h83, 8'hec, 8'h08,               // 27 sub esp,8
                8'h83, 8'hc4, 8'h04,               // 30 add esp,4
                8'h53, 8'hc9, 8'hc3,               // 33 push ebx / leave / ret
                8'hf4                              // 36 not decoded, halts
        };

        tb_clock u_tb_clock (.hold(hold), .clk2(clk2), .reset(reset));

        cpu_top u_cpu_top (
                .clk2(clk2), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
                .prog_data(prog_data), .eax(eax), .ebx(ebx), .ebp(ebp), .esp(esp),
                .eip(eip), .retire(retire), .halted(halted)
        );

        bind cpu_top cpu_assert u_cpu_assert (
                .clk2(clk2), .reset(reset), .win(win), .eax(eax), .ebx(ebx), .ebp(ebp),
                .esp(esp), .eip(eip), .retire(retire), .halted(halted)
        );

        task automatic load_program();
                for (int i = 0; i < 37; i++) begin
                        @(posedge clk2);
                        prog_we   <= 1'b1;
                        prog_addr <= 8'(i);
                        prog_data <= prog[i];
                end
                @(posedge clk2);
                prog_we <= 1'b0;
                hold    <= 1'b0;
        endtask

        task automatic give_up(input string what);
                ended = 1'b1;
                $display("timeout: %s", what);
                $display("TEST RESULT: FAIL");
                $fatal(1, "simulation stopped on timeout");
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
                ended = 1'b1;
                $display("FAIL %s expected %0d actual %0d", name, exp, act);
                $display("TEST RESULT: FAIL");
                $fatal(1, "simulation stopped on a wrong value");
        endtask

        initial begin
                int n;
                ended     = 1'b0;
                hold      = 1'b1;
                prog_we   = 1'b0;
                prog_addr = 8'h00;
                prog_data = 8'h00;
                load_program();
                for (n = 0; n < 20 && reset; n++) @(posedge clk2);
                if (reset) give_up("reset was never released");
                for (n = 0; n < 400 && !halted; n++) @(posedge clk2);
                if (!halted) begin
                        give_up("halted never rose, the program did not reach its end");
                end else if (eip !== 32'd36) begin
                        report_mismatch("halt_address", 32'd36, eip); // last byte of the program
                end else begin
                        repeat (4) @(posedge clk2); // halt must hold with no retire
                        ended = 1'b1;
                        $display("TEST RESULT: PASS");
                        $finish;
                end
        end

        final begin
                if (!ended) $display("TEST RESULT: FAIL");
        end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
        input  logic hold,
        output logic clk2,
        output logic reset
);

        initial begin
                clk2 = 1'b0;
                forever #4 clk2 = ~clk2; // 8 ns period
        end

        // reset stays high while the program loads, then two more cycles
        initial begin
                reset = 1'b1;
                for (int n = 0; n < 1000 && hold !== 1'b0; n++) @(posedge clk2);
                repeat (2) @(posedge clk2);
                reset <= 1'b0;
        end

endmodule

// ==== cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert (
        input logic        clk2,
        input logic        reset,
        input logic [47:0] win,
        input logic [31:0] eax,
        input logic [31:0] ebx,
        input logic [31:0] ebp,
        input logic [31:0] esp,
        input logic [31:0] eip,
        input logic        retire,
        input logic        halted
);

        logic        take;  // registers show a finished instruction
        logic        armed; // a snapshot is held
        logic        check;
        logic        first;
        logic [31:0] s_eax, s_ebx, s_ebp, s_esp, s_eip;
        logic [47:0] s_win; // bytes at the old eip
        logic [31:0] shadow [cpu_pkg::stack_words];
        logic [31:0] x_eax, x_ebx, x_ebp, x_esp, x_eip;
        logic [31:0] x_push;
        logic        do_push;
        logic [7:0]  opc;
        logic [31:0] b1, b2, i32, stk_top;

        assign opc     = s_win[47:40];
        assign b1      = {{24{s_win[39]}}, s_win[39:32]}; // byte after the opcode
        assign b2      = {{24{s_win[31]}}, s_win[31:24]}; // byte after modrm
        assign i32     = {s_win[15:8], s_win[23:16], s_win[31:24], s_win[39:32]};
        assign stk_top = shadow[s_esp[7:2]];
        assign check   = take && armed;
        assign first   = take && !armed;

        // x86 semantics of the kept subset
        always_comb begin
                {x_eax, x_ebx, x_ebp, x_esp, x_eip} = {s_eax, s_ebx, s_ebp, s_esp, s_eip};
                x_push  = 32'd0;
                do_push = 1'b0;
                case (opc)
                cpu_pkg::opc_push_ebp, cpu_pkg::opc_push_eax, cpu_pkg::opc_push_ebx: begin
                        x_esp   = s_esp - 32'd4;
                        x_eip   = s_eip + 32'd1;
                        do_push = 1'b1;
                        x_push  = (opc == cpu_pkg::opc_push_ebp) ? s_ebp :
                                  (opc == cpu_pkg::opc_push_eax) ? s_eax : s_ebx;
                end
                cpu_pkg::opc_pop_ebp: begin
                        x_ebp = stk_top;
                        x_esp = s_esp + 32'd4;
                        x_eip = s_eip + 32'd1;
                end
                cpu_pkg::opc_mov_rm: begin
                        if (s_win[39:32] == 8'he5) x_ebp = s_esp;
                        else x_ebx = s_eax;
                        x_eip = s_eip + 32'd2;
                end
                cpu_pkg::opc_mov_eax_imm: begin
                        x_eax = i32;
                        x_eip = s_eip + 32'd5;
                end
                cpu_pkg::opc_push_imm8: begin
                        x_esp   = s_esp - 32'd4;
                        x_eip   = s_eip + 32'd2;
                        do_push = 1'b1;
                        x_push  = b1;
                end
                cpu_pkg::opc_grp83: begin
                        x_esp = (s_win[39:32] == 8'hc4) ? s_esp + b2 : s_esp - b2;
                        x_eip = s_eip + 32'd3;
                end
                cpu_pkg::opc_add_rm: begin
                        x_eax = s_eax + s_ebx;
                        x_eip = s_eip + 32'd2;
                end
                cpu_pkg::opc_jmp8: x_eip = s_eip + 32'd2 + b1;
                cpu_pkg::opc_call: begin
                        x_esp   = s_esp - 32'd4;
                        x_eip   = s_eip + 32'd5 + i32;
                        do_push = 1'b1;
                        x_push  = s_eip + 32'd5; // return address
                end
                cpu_pkg::opc_ret: begin
                        x_eip = stk_top;
                        x_esp = s_esp + 32'd4;
                end
                cpu_pkg::opc_leave: begin
                        x_esp = s_ebp + 32'd4;
                        x_ebp = shadow[s_ebp[7:2]];
                        x_eip = s_eip + 32'd1;
                end
                default: ;
                endcase
        end

        always_ff @(posedge clk2 or posedge reset) begin
                if (reset) begin
                        take  <= 1'b1;
                        armed <= 1'b0;
                end else begin
                        take <= retire;
                        if (take) armed <= 1'b1;
                end
        end

        always_ff @(posedge clk2) begin
                if (take) begin
                        {s_eax, s_ebx, s_ebp, s_esp, s_eip} <= {eax, ebx, ebp, esp, eip};
                        s_win <= win;
                end
                if (check && do_push) shadow[x_esp[7:2]] <= x_push;
        end

        // values in the order eip, esp, retire, halted
        a_reset_state: assert property (@(posedge clk2) disable iff (reset)
                first |-> eip == 32'd0 && esp == cpu_pkg::esp_reset && !retire && !halted)
                else $error("FAIL reset_state expected %h %h 0 0 actual %h %h %b %b",
                            32'd0, cpu_pkg::esp_reset, $sampled(eip), $sampled(esp),
                            $sampled(retire), $sampled(halted));
        a_eax: assert property (@(posedge clk2) disable iff (reset) check |-> eax == x_eax)
                else $error("FAIL eax_at_retire op %h expected %h actual %h",
                            $sampled(opc), $sampled(x_eax), $sampled(eax));
        a_ebx: assert property (@(posedge clk2) disable iff (reset) check |-> ebx == x_ebx)
                else $error("FAIL ebx_at_retire op %h expected %h actual %h",
                            $sampled(opc), $sampled(x_ebx), $sampled(ebx));
        a_ebp: assert property (@(posedge clk2) disable iff (reset) check |-> ebp == x_ebp)
                else $error("FAIL ebp_at_retire op %h expected %h actual %h",
                            $sampled(opc), $sampled(x_ebp), $sampled(ebp));
        a_esp: assert property (@(posedge clk2) disable iff (reset) check |-> esp == x_esp)
                else $error("FAIL esp_at_retire op %h expected %h actual %h",
                            $sampled(opc), $sampled(x_esp), $sampled(esp));
        a_eip: assert property (@(posedge clk2) disable iff (reset) check |-> eip == x_eip)
                else $error("FAIL eip_at_retire op %h expected %h actual %h",
                            $sampled(opc), $sampled(x_eip), $sampled(eip));
        a_halt_holds: assert property (@(posedge clk2) disable iff (reset)
                halted |=> halted && !retire)
                else $error("halted dropped or an instruction retired after the halt");

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
        input  logic        clk2,
        input  logic        reset,
        input  logic        prog_we,
        input  logic [7:0]  prog_addr,
        input  logic [7:0]  prog_data,
        output logic [31:0] eax,
        output logic [31:0] ebx,
        output logic [31:0] ebp,
        output logic [31:0] esp,
        output logic [31:0] eip,
        output logic        retire,
        output logic        halted
);

        logic [47:0] win;
        logic [3:0]  reg_load_1, reg_load_2, reg_load_3;
        logic [3:0]  select_1, select_2, select_3;
        logic [2:0]  alu_op_1, alu_op_2, alu_op_3;
        logic [1:0]  num_steps;
        logic        illegal;
        logic [3:0]  num_of_ope;
        logic [3:0]  cur_load;
        logic [3:0]  cur_select;
        logic [2:0]  cur_op;
        logic        exec_en;
        logic        advance;
        logic [5:0]  stk_addr;
        logic [31:0] stk_wdata;
        logic [31:0] stk_rdata;
        logic        stk_we;

        code_rom u_code_rom (
                .clk2(clk2), .prog_we(prog_we), .prog_addr(prog_addr),
                .prog_data(prog_data), .eip(eip), .win(win)
        );

        decode u_decode (
                .reset(reset), .clk2(clk2), .ope(win[47:32]),
                .reg_load_1(reg_load_1), .select_1(select_1),
                .reg_load_2(reg_load_2), .select_2(select_2),
                .reg_load_3(reg_load_3), .select_3(select_3),
                .alu_op_1(alu_op_1), .alu_op_2(alu_op_2), .alu_op_3(alu_op_3),
                .num_steps(num_steps), .illegal(illegal), .num_of_ope(num_of_ope)
        );

        step_seq u_step_seq (
                .reset(reset), .clk2(clk2), .num_steps(num_steps), .illegal(illegal),
                .reg_load_1(reg_load_1), .select_1(select_1), .alu_op_1(alu_op_1),
                .reg_load_2(reg_load_2), .select_2(select_2), .alu_op_2(alu_op_2),
                .reg_load_3(reg_load_3), .select_3(select_3), .alu_op_3(alu_op_3),
                .cur_load(cur_load), .cur_select(cur_select), .cur_op(cur_op),
                .exec_en(exec_en), .advance(advance), .retire(retire), .halted(halted)
        );

        exec_unit u_exec_unit (
                .reset(reset), .clk2(clk2), .exec_en(exec_en), .advance(advance),
                .cur_load(cur_load), .cur_select(cur_select), .cur_op(cur_op),
                .num_of_ope(num_of_ope), .win(win), .stk_rdata(stk_rdata),
                .stk_addr(stk_addr), .stk_wdata(stk_wdata), .stk_we(stk_we),
                .eax(eax), .ebx(ebx), .ebp(ebp), .esp(esp), .eip(eip)
        );

        stack_ram u_stack_ram (
                .clk2(clk2), .we(stk_we), .addr(stk_addr),
                .wdata(stk_wdata), .rdata(stk_rdata)
        );

endmodule

// ==== stack_ram.sv ====
`timescale 1ns/1ps

module stack_ram (
        input  logic        clk2,
        input  logic        we,
        input  logic [5:0]  addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata
);

        logic [31:0] mem [cpu_pkg::stack_words];

        always_ff @(posedge clk2) begin
                if (we) begin
                        mem[addr] <= wdata;
                end
        end

        assign rdata = mem[addr]; // pop sees the word in the same step

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
        input  logic        reset,
        input  logic        clk2,
        input  logic        exec_en,
        input  logic        advance,
        input  logic [3:0]  cur_load,
        input  logic [3:0]  cur_select,
        input  logic [2:0]  cur_op,
        input  logic [3:0]  num_of_ope,
        input  logic [47:0] win,
        input  logic [31:0] stk_rdata,
        output logic [5:0]  stk_addr,
        output logic [31:0] stk_wdata,
        output logic        stk_we,
        output logic [31:0] eax,
        output logic [31:0] ebx,
        output logic [31:0] ebp,
        output logic [31:0] esp,
        output logic [31:0] eip
);

        logic [7:0]  imm8_byte;
        logic [31:0] imm8;
        logic [31:0] imm32;
        logic [31:0] len;
        logic [31:0] opnd;
        logic [31:0] dst_val;
        logic [31:0] add_a;
        logic [31:0] add_b;
        logic [31:0] add_c;
        logic [31:0] sum;

        // the 83 group has its byte after modrm, push and jmp right after the opcode
        assign imm8_byte = (cur_op == cpu_pkg::op_add_imm || cur_op == cpu_pkg::op_sub_imm) ?
                           win[31:24] : win[39:32];
        assign imm8  = {{24{imm8_byte[7]}}, imm8_byte};
        assign imm32 = {win[15:8], win[23:16], win[31:24], win[39:32]}; // little endian
        assign len   = {28'd0, num_of_ope};

        always_comb begin
                case (cur_select)
                cpu_pkg::src_esp:   opnd = esp;
                cpu_pkg::src_ebp:   opnd = ebp;
                cpu_pkg::src_eax:   opnd = eax;
                cpu_pkg::src_ebx:   opnd = ebx;
                cpu_pkg::src_eip:   opnd = eip;
                cpu_pkg::src_imm8:  opnd = imm8;
                cpu_pkg::src_imm32: opnd = imm32;
                default:            opnd = stk_rdata;
                endcase
        end

        always_comb begin
                case (cur_load)
                cpu_pkg::dst_esp: dst_val = esp;
                cpu_pkg::dst_ebp: dst_val = ebp;
                cpu_pkg::dst_eax: dst_val = eax;
                cpu_pkg::dst_ebx: dst_val = ebx;
                cpu_pkg::dst_eip: dst_val = eip;
                default:          dst_val = 32'd0;
                endcase
        end

        // operand steering for the single adder
        always_comb begin
                add_a = opnd;
                add_b = 32'd0;
                add_c = 32'd0;
                if (advance) begin
                        add_a = eip;
                        add_c = len;
                end else begin
                        case (cur_op)
                        cpu_pkg::op_add_imm: begin
                                add_a = dst_val;
                                add_b = opnd;
                        end
                        cpu_pkg::op_sub_imm: begin
                                add_a = dst_val;
                                add_b = ~opnd;
                                add_c = 32'd1; // two's complement
                        end
                        cpu_pkg::op_dec4: add_b = 32'hffff_fffc;
                        cpu_pkg::op_inc4: add_b = 32'd4;
                        cpu_pkg::op_next_eip: begin
                                add_a = eip;
                                add_c = len;
                        end
                        cpu_pkg::op_rel: begin
                                add_a = eip;
                                add_b = opnd;
                                add_c = len;
                        end
                        default: ;
                        endcase
                end
        end

        assign sum       = add_a + add_b + add_c;
        assign stk_addr  = esp[7:2]; // byte address 256 wraps to word 0
        assign stk_wdata = sum;
        assign stk_we    = exec_en && (cur_load == cpu_pkg::dst_stk);

        always_ff @(posedge clk2 or posedge reset) begin
                if (reset) begin
                        eax <= 32'd0;
                        ebx <= 32'd0;
                        ebp <= 32'd0;
                        esp <= cpu_pkg::esp_reset;
                        eip <= 32'd0;
                end else if (advance) begin
                        eip <= sum;
                end else if (exec_en) begin
                        case (cur_load)
                        cpu_pkg::dst_esp: esp <= sum;
                        cpu_pkg::dst_ebp: ebp <= sum;
                        cpu_pkg::dst_eax: eax <= sum;
                        cpu_pkg::dst_ebx: ebx <= sum;
                        cpu_pkg::dst_eip: eip <= sum;
                        default: ; // none or stack write
                        endcase
                end
        end

endmodule

// ==== step_seq.sv ====
`timescale 1ns/1ps

module step_seq (
        input  logic       reset,
        input  logic       clk2,
        input  logic [1:0] num_steps,
        input  logic       illegal,
        input  logic [3:0] reg_load_1,
        input  logic [3:0] select_1,
        input  logic [2:0] alu_op_1,
        input  logic [3:0] reg_load_2,
        input  logic [3:0] select_2,
        input  logic [2:0] alu_op_2,
        input  logic [3:0] reg_load_3,
        input  logic [3:0] select_3,
        input  logic [2:0] alu_op_3,
        output logic [3:0] cur_load,
        output logic [3:0] cur_select,
        output logic [2:0] cur_op,
        output logic       exec_en,
        output logic       advance,
        output logic       retire,
        output logic       halted
);

        logic [1:0]  step;
        logic        in_adv;  // advance cycle
        logic        eip_hit; // a step of this instruction loaded eip
        logic [1:0]  n_lat;
        logic [10:0] lat_2;   // later steps held, win moves once eip is loaded
        logic [10:0] lat_3;
        logic        last;

        always_comb begin
                case (step)
                2'd1: {cur_load, cur_select, cur_op} = lat_2;
                2'd2: {cur_load, cur_select, cur_op} = lat_3;
                default: {cur_load, cur_select, cur_op} = {reg_load_1, select_1, alu_op_1};
                endcase
        end

        assign exec_en = !halted && !in_adv && !(step == 2'd0 && illegal);
        assign retire  = in_adv;
        assign advance = in_adv && !eip_hit;
        assign last    = (step == 2'd0) ? (num_steps == 2'd1) : (step == n_lat - 2'd1);

        always_ff @(posedge clk2) begin
                if (exec_en && step == 2'd0) begin
                        lat_2 <= {reg_load_2, select_2, alu_op_2};
                        lat_3 <= {reg_load_3, select_3, alu_op_3};
                end
        end

        always_ff @(posedge clk2 or posedge reset) begin
                if (reset) begin
                        step    <= 2'd0;
                        in_adv  <= 1'b0;
                        eip_hit <= 1'b0;
                        n_lat   <= 2'd0;
                        halted  <= 1'b0;
                end else if (in_adv) begin
                        in_adv  <= 1'b0;
                        eip_hit <= 1'b0;
                end else if (exec_en) begin
                        if (step == 2'd0) begin
                                n_lat <= num_steps;
                        end
                        if (cur_load == cpu_pkg::dst_eip) begin
                                eip_hit <= 1'b1;
                        end
                        if (last) begin
                                step   <= 2'd0;
                                in_adv <= 1'b1;
                        end else begin
                                step <= step + 2'd1;
                        end
                end else if (step == 2'd0 && illegal) begin
                        halted <= 1'b1; // sticky until reset
                end
        end

endmodule

// ==== decode.sv ====
`timescale 1ns/1ps

module decode (
        input  logic        reset,
        input  logic        clk2,
        input  logic [15:0] ope,
        output logic [3:0]  reg_load_1,
        output logic [3:0]  select_1,
        output logic [3:0]  reg_load_2,
        output logic [3:0]  select_2,
        output logic [3:0]  reg_load_3,
        output logic [3:0]  select_3,
        output logic [2:0]  alu_op_1,
        output logic [2:0]  alu_op_2,
        output logic [2:0]  alu_op_3,
        output logic [1:0]  num_steps,
        output logic        illegal,
        output logic [3:0]  num_of_ope
);

        logic [10:0] s1; // {load, select, op}
        logic [10:0] s2;
        logic [10:0] s3;
        logic [3:0]  len;

        assign {reg_load_1, select_1, alu_op_1} = s1;
        assign {reg_load_2, select_2, alu_op_2} = s2;
        assign {reg_load_3, select_3, alu_op_3} = s3;

        always_comb begin
                s1 = {cpu_pkg::dst_none, cpu_pkg::src_esp, cpu_pkg::op_pass};
                s2 = {cpu_pkg::dst_none, cpu_pkg::src_esp, cpu_pkg::op_pass};
                s3 = {cpu_pkg::dst_none, cpu_pkg::src_esp, cpu_pkg::op_pass};
                num_steps = 2'd0;
                len = 4'd0;
                illegal = 1'b0;
                case (ope[15:8])
                cpu_pkg::opc_push_ebp, cpu_pkg::opc_push_eax, cpu_pkg::opc_push_ebx: begin
                        num_steps = 2'd2;
                        len = 4'd1;
                        s1 = {cpu_pkg::dst_esp, cpu_pkg::src_esp, cpu_pkg::op_dec4};
                        s2 = {cpu_pkg::dst_stk, cpu_pkg::src_ebp, cpu_pkg::op_pass};
                        if (ope[15:8] == cpu_pkg::opc_push_eax) begin
                                s2[6:3] = cpu_pkg::src_eax;
                        end else if (ope[15:8] == cpu_pkg::opc_push_ebx) begin
                                s2[6:3] = cpu_pkg::src_ebx;
                        end
                end
                cpu_pkg::opc_pop_ebp: begin
                        num_steps = 2'd2;
                        len = 4'd1;
                        s1 = {cpu_pkg::dst_ebp, cpu_pkg::src_stk, cpu_pkg::op_pass};
                        s2 = {cpu_pkg::dst_esp, cpu_pkg::src_esp, cpu_pkg::op_inc4};
                end
                cpu_pkg::opc_mov_rm: begin
                        num_steps = 2'd1;
                        len = 4'd2;
                        if (ope[7:0] == 8'he5) begin // mov ebp,esp
                                s1 = {cpu_pkg::dst_ebp, cpu_pkg::src_esp, cpu_pkg::op_pass};
                        end else if (ope[7:0] == 8'hc3) begin // mov ebx,eax
                                s1 = {cpu_pkg::dst_ebx, cpu_pkg::src_eax, cpu_pkg::op_pass};
                        end else begin
                                illegal = 1'b1;
                        end
                end
                cpu_pkg::opc_mov_eax_imm: begin
                        num_steps = 2'd1;
                        len = 4'd5;
                        s1 = {cpu_pkg::dst_eax, cpu_pkg::src_imm32, cpu_pkg::op_pass};
                end
                cpu_pkg::opc_push_imm8: begin
                        num_steps = 2'd2;
                        len = 4'd2;
                        s1 = {cpu_pkg::dst_esp, cpu_pkg::src_esp, cpu_pkg::op_dec4};
                        s2 = {cpu_pkg::dst_stk, cpu_pkg::src_imm8, cpu_pkg::op_pass};
                end
                cpu_pkg::opc_grp83: begin
                        num_steps = 2'd1;
                        len = 4'd3;
                        if (ope[7:0] == 8'hc4) begin // add esp,imm8
                                s1 = {cpu_pkg::dst_esp, cpu_pkg::src_imm8, cpu_pkg::op_add_imm};
                        end else if (ope[7:0] == 8'hec) begin // sub esp,imm8
                                s1 = {cpu_pkg::dst_esp, cpu_pkg::src_imm8, cpu_pkg::op_sub_imm};
                        end else begin
                                illegal = 1'b1;
                        end
                end
                cpu_pkg::opc_add_rm: begin
                        num_steps = 2'd1;
                        len = 4'd2;
                        s1 = {cpu_pkg::dst_eax, cpu_pkg::src_ebx, cpu_pkg::op_add_imm};
                        illegal = (ope[7:0] != 8'hd8); // only add eax,ebx
                end
                cpu_pkg::opc_jmp8: begin
                        num_steps = 2'd2; // idle first step while the length registers
                        len = 4'd2;
                        s2 = {cpu_pkg::dst_eip, cpu_pkg::src_imm8, cpu_pkg::op_rel};
                end
                cpu_pkg::opc_call: begin
                        num_steps = 2'd3;
                        len = 4'd5;
                        s1 = {cpu_pkg::dst_esp, cpu_pkg::src_esp, cpu_pkg::op_dec4};
                        s2 = {cpu_pkg::dst_stk, cpu_pkg::src_eip, cpu_pkg::op_next_eip};
                        s3 = {cpu_pkg::dst_eip, cpu_pkg::src_imm32, cpu_pkg::op_rel};
                end
                cpu_pkg::opc_ret: begin
                        num_steps = 2'd2;
                        len = 4'd1;
                        s1 = {cpu_pkg::dst_eip, cpu_pkg::src_stk, cpu_pkg::op_pass};
                        s2 = {cpu_pkg::dst_esp, cpu_pkg::src_esp, cpu_pkg::op_inc4};
                end
                cpu_pkg::opc_leave: begin
                        num_steps = 2'd3;
                        len = 4'd1;
                        s1 = {cpu_pkg::dst_esp, cpu_pkg::src_ebp, cpu_pkg::op_pass};
                        s2 = {cpu_pkg::dst_ebp, cpu_pkg::src_stk, cpu_pkg::op_pass};
                        s3 = {cpu_pkg::dst_esp, cpu_pkg::src_esp, cpu_pkg::op_inc4};
                end
                default: illegal = 1'b1;
                endcase
        end

        always_ff @(posedge clk2 or posedge reset) begin
                if (reset) begin
                        num_of_ope <= 4'h0;
                end else begin
                        num_of_ope <= len; // valid from the second cycle of an instruction
                end
        end

endmodule

// ==== code_rom.sv ====
`timescale 1ns/1ps

module code_rom (
        input  logic        clk2,
        input  logic        prog_we,
        input  logic [7:0]  prog_addr,
        input  logic [7:0]  prog_data,
        input  logic [31:0] eip,
        output logic [47:0] win
);

        logic [7:0] mem [cpu_pkg::code_bytes];

        always_ff @(posedge clk2) begin
                if (prog_we) begin
                        mem[prog_addr] <= prog_data; // loaded while reset is high
                end
        end

        // opcode, modrm and up to four immediate bytes in one read
        always_comb begin
                for (int i = 0; i < 6; i++) begin
                        win[47 - 8*i -: 8] = mem[(eip + 32'(i)) % cpu_pkg::code_bytes];
                end
        end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

        // destination codes, one per micro-step
        localparam logic [3:0] dst_none = 4'd0;
        localparam logic [3:0] dst_esp  = 4'd1;
        localparam logic [3:0] dst_ebp  = 4'd2;
        localparam logic [3:0] dst_eax  = 4'd3;
        localparam logic [3:0] dst_ebx  = 4'd4;
        localparam logic [3:0] dst_eip  = 4'd5;
        localparam logic [3:0] dst_stk  = 4'd6; // stack word at esp

        // source codes
        localparam logic [3:0] src_esp   = 4'd0;
        localparam logic [3:0] src_ebp   = 4'd1;
        localparam logic [3:0] src_eax   = 4'd2;
        localparam logic [3:0] src_ebx   = 4'd3;
        localparam logic [3:0] src_eip   = 4'd4;
        localparam logic [3:0] src_imm8  = 4'd5; // sign extended
        localparam logic [3:0] src_imm32 = 4'd6;
        localparam logic [3:0] src_stk   = 4'd7; // stack word at esp

        // step operations
        localparam logic [2:0] op_pass     = 3'd0;
        localparam logic [2:0] op_add_imm  = 3'd1; // destination plus source
        localparam logic [2:0] op_sub_imm  = 3'd2; // destination minus source
        localparam logic [2:0] op_dec4     = 3'd3;
        localparam logic [2:0] op_inc4     = 3'd4;
        localparam logic [2:0] op_next_eip = 3'd5; // eip plus length
        localparam logic [2:0] op_rel      = 3'd6; // eip plus length plus source

        localparam logic [31:0] esp_reset = 32'd256;
        localparam int code_bytes  = 256;
        localparam int stack_words = 64;

        // first opcode bytes
        localparam logic [7:0] opc_push_ebp    = 8'h55;
        localparam logic [7:0] opc_push_eax    = 8'h50;
        localparam logic [7:0] opc_push_ebx    = 8'h53;
        localparam logic [7:0] opc_pop_ebp     = 8'h5d;
        localparam logic [7:0] opc_mov_rm      = 8'h89;
        localparam logic [7:0] opc_mov_eax_imm = 8'hb8;
        localparam logic [7:0] opc_push_imm8   = 8'h6a;
        localparam logic [7:0] opc_grp83       = 8'h83;
        localparam logic [7:0] opc_add_rm      = 8'h01;
        localparam logic [7:0] opc_jmp8        = 8'heb;
        localparam logic [7:0] opc_call        = 8'he8;
        localparam logic [7:0] opc_ret         = 8'hc3;
        localparam logic [7:0] opc_leave       = 8'hc9;

endpackage
